// ==== src/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [127:0] lc3b_line;
	// bit 0 enables the low byte
	typedef logic [1:0] lc3b_mem_wmask;

	// pipeline side word request
	typedef struct packed {
		logic read;
		logic write;
		lc3b_word address;
		lc3b_word wdata;
		lc3b_mem_wmask byte_enable;
	} mem_req_t;

	typedef struct packed {
		logic resp;
		lc3b_word rdata;
	} mem_resp_t;

	// line request toward physical memory with a line aligned address
	typedef struct packed {
		logic read;
		logic write;
		lc3b_word address;
		lc3b_line wdata;
	} pmem_req_t;

	// data addresses from here up belong to the counter block
	localparam lc3b_word io_base = 16'hFFF0;
	localparam logic [3:0] io_inst_hits = 4'h0;
	localparam logic [3:0] io_inst_misses = 4'h2;
	localparam logic [3:0] io_data_hits = 4'h4;
	localparam logic [3:0] io_data_misses = 4'h6;

endpackage

`default_nettype wire

// ==== src/cache_control.sv ====
`default_nettype none

module cache_control (
	input logic clk,
	input logic rst_i,
	input logic mem_read_i,
	input logic mem_write_i,
	input logic hit_i,
	input logic dirty_i,
	input logic pmem_resp_i,
	output logic mem_resp_o,
	output logic pmem_read_o,
	output logic pmem_write_o,
	output logic load_line_o,
	output logic load_word_o,
	output logic set_dirty_o,
	output logic hit_pulse_o,
	output logic miss_pulse_o
);

	typedef enum logic [1:0] {idle, compare, write_back, fill} state_t;

	state_t state;
	state_t next_state;
	// set once the current request has missed
	logic refill;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= idle;
			refill <= 1'b0;
		end else begin
			state <= next_state;
			if (state == idle)
				refill <= 1'b0;
			else if (state == compare && !hit_i)
				refill <= 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		mem_resp_o = 1'b0;
		pmem_read_o = 1'b0;
		pmem_write_o = 1'b0;
		load_line_o = 1'b0;
		load_word_o = 1'b0;
		set_dirty_o = 1'b0;
		hit_pulse_o = 1'b0;
		miss_pulse_o = 1'b0;
		case (state)
			idle: begin
				if (mem_read_i || mem_write_i)
					next_state = compare;
			end
			compare: begin
				if (hit_i) begin
					mem_resp_o = 1'b1;
					load_word_o = mem_write_i;
					set_dirty_o = mem_write_i;
					hit_pulse_o = !refill;
					next_state = idle;
				end else begin
					miss_pulse_o = !refill;
					// victim goes out before the fill read
					next_state = dirty_i ? write_back : fill;
				end
			end
			write_back: begin
				pmem_write_o = 1'b1;
				if (pmem_resp_i)
					next_state = fill;
			end
			fill: begin
				pmem_read_o = 1'b1;
				if (pmem_resp_i) begin
					load_line_o = 1'b1;
					next_state = compare;
				end
			end
			default: next_state = idle;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/cache.sv ====
`default_nettype none

module cache
	import lc3b_types::*;
#(
	parameter int index_bits = 3
) (
	input logic clk,
	input logic rst_i,
	input mem_req_t req_i,
	input logic pmem_resp_i,
	input lc3b_line pmem_rdata_i,
	output mem_resp_t resp_o,
	output pmem_req_t pmem_req_o,
	output logic hit_o,
	output logic miss_o
);

	localparam int tag_bits = 12 - index_bits;
	localparam int sets = 1 << index_bits;

	logic [tag_bits-1:0] tag_array [sets];
	lc3b_line data_array [sets];
	logic [sets-1:0] valid_array;
	logic [sets-1:0] dirty_array;

	// address splits into tag, index, word and byte
	logic [tag_bits-1:0] tag;
	logic [index_bits-1:0] index;
	logic [2:0] word_sel;

	logic hit;
	logic dirty;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	logic load_line;
	logic load_word;
	logic set_dirty;
	lc3b_line cur_line;
	lc3b_word cur_word;
	lc3b_word merged_word;
	lc3b_line merged_line;

	assign tag = req_i.address[15:4+index_bits];
	assign index = req_i.address[3+index_bits:4];
	assign word_sel = req_i.address[3:1];

	assign cur_line = data_array[index];
	assign cur_word = cur_line[word_sel*16 +: 16];
	assign hit = valid_array[index] && (tag_array[index] == tag);
	assign dirty = valid_array[index] && dirty_array[index];

	// only the enabled bytes of the addressed word change
	always_comb begin
		merged_word = cur_word;
		if (req_i.byte_enable[0])
			merged_word[7:0] = req_i.wdata[7:0];
		if (req_i.byte_enable[1])
			merged_word[15:8] = req_i.wdata[15:8];
		merged_line = cur_line;
		merged_line[word_sel*16 +: 16] = merged_word;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_array <= '0;
			dirty_array <= '0;
		end else if (load_line) begin
			valid_array[index] <= 1'b1;
			dirty_array[index] <= 1'b0;
		end else if (set_dirty) begin
			dirty_array[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_line) begin
			tag_array[index] <= tag;
			data_array[index] <= pmem_rdata_i;
		end else if (load_word) begin
			data_array[index] <= merged_line;
		end
	end

	assign resp_o.resp = mem_resp;
	assign resp_o.rdata = cur_word;

	// write-back targets the victim line and fill the requested line
	assign pmem_req_o.read = pmem_read;
	assign pmem_req_o.write = pmem_write;
	assign pmem_req_o.address = pmem_write ? {tag_array[index], index, 4'h0}
		: {req_i.address[15:4], 4'h0};
	assign pmem_req_o.wdata = cur_line;

	cache_control control (
		.clk,
		.rst_i,
		.mem_read_i(req_i.read),
		.mem_write_i(req_i.write),
		.hit_i(hit),
		.dirty_i(dirty),
		.pmem_resp_i,
		.mem_resp_o(mem_resp),
		.pmem_read_o(pmem_read),
		.pmem_write_o(pmem_write),
		.load_line_o(load_line),
		.load_word_o(load_word),
		.set_dirty_o(set_dirty),
		.hit_pulse_o(hit_o),
		.miss_pulse_o(miss_o)
	);

endmodule

`default_nettype wire

// ==== src/cache_arbiter.sv ====
`default_nettype none

module cache_arbiter
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_i,
	input pmem_req_t i_req_i,
	input pmem_req_t d_req_i,
	input logic physical_resp_i,
	output pmem_req_t physical_req_o,
	output logic i_pmem_resp_o,
	output logic d_pmem_resp_o
);

	// busy from grant until the cycle after the response
	logic busy;
	logic own_d;
	logic resp_q;
	logic i_active;
	logic d_active;

	assign i_active = i_req_i.read || i_req_i.write;
	assign d_active = d_req_i.read || d_req_i.write;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy <= 1'b0;
			own_d <= 1'b0;
			resp_q <= 1'b0;
			physical_req_o <= '0;
		end else begin
			resp_q <= busy && physical_resp_i;
			if (!busy) begin
				// data side wins a tie
				if (d_active) begin
					busy <= 1'b1;
					own_d <= 1'b1;
					physical_req_o <= d_req_i;
				end else if (i_active) begin
					busy <= 1'b1;
					own_d <= 1'b0;
					physical_req_o <= i_req_i;
				end
			end else if (resp_q) begin
				busy <= 1'b0;
			end else if (physical_resp_i) begin
				physical_req_o.read <= 1'b0;
				physical_req_o.write <= 1'b0;
			end
		end
	end

	// response pulse goes only to the owner
	assign i_pmem_resp_o = resp_q && !own_d;
	assign d_pmem_resp_o = resp_q && own_d;

endmodule

`default_nettype wire

// ==== src/perf_io.sv ====
`default_nettype none

module perf_io
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_i,
	input mem_req_t req_i,
	input logic i_hit_i,
	input logic i_miss_i,
	input logic d_hit_i,
	input logic d_miss_i,
	output mem_resp_t resp_o
);

	// 0 inst hits, 1 inst misses, 2 data hits, 3 data misses
	logic [15:0] counts [4];
	logic [3:0] events;
	logic accept;
	lc3b_word sel_count;

	assign events = {d_miss_i, d_hit_i, i_miss_i, i_hit_i};
	// one response per held request
	assign accept = (req_i.read || req_i.write) && !resp_o.resp;

	always_comb begin
		case (req_i.address[3:0])
			io_inst_hits: sel_count = counts[0];
			io_inst_misses: sel_count = counts[1];
			io_data_hits: sel_count = counts[2];
			io_data_misses: sel_count = counts[3];
			default: sel_count = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i || (accept && req_i.write)) begin
			for (int k = 0; k < 4; k++)
				counts[k] <= '0;
		end else begin
			for (int k = 0; k < 4; k++)
				if (events[k] && counts[k] != 16'hFFFF)
					counts[k] <= counts[k] + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			resp_o.resp <= 1'b0;
		else
			resp_o.resp <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept)
			resp_o.rdata <= req_i.write ? 16'h0000 : sel_count;
	end

endmodule

`default_nettype wire

// ==== src/lc3b_memory.sv ====
`default_nettype none

module lc3b_memory
	import lc3b_types::*;
#(
	parameter int index_bits = 3
) (
	input logic clk,
	input logic rst_i,
	input mem_req_t inst_req_i,
	input mem_req_t data_req_i,
	input logic physical_resp_i,
	input lc3b_line physical_rdata_i,
	output mem_resp_t inst_resp_o,
	output mem_resp_t data_resp_o,
	output logic physical_read_o,
	output logic physical_write_o,
	output lc3b_word physical_address_o,
	output lc3b_line physical_wdata_o
);

	mem_req_t inst_req;
	mem_req_t dcache_req;
	mem_req_t io_req;
	mem_resp_t dcache_resp;
	mem_resp_t io_resp;
	pmem_req_t i_pmem_req;
	pmem_req_t d_pmem_req;
	pmem_req_t physical_req;
	logic i_pmem_resp;
	logic d_pmem_resp;
	lc3b_line pmem_rdata;
	logic i_hit;
	logic i_miss;
	logic d_hit;
	logic d_miss;
	logic io_sel;

	// instruction side never writes
	always_comb begin
		inst_req = inst_req_i;
		inst_req.write = 1'b0;
	end

	// top of the data space goes to the counters
	assign io_sel = data_req_i.address >= io_base;
	assign dcache_req = io_sel ? '0 : data_req_i;
	assign io_req = io_sel ? data_req_i : '0;

	assign data_resp_o.resp = dcache_resp.resp || io_resp.resp;
	assign data_resp_o.rdata = io_resp.resp ? io_resp.rdata : dcache_resp.rdata;

	// line lines up with the registered response pulse
	always_ff @(posedge clk)
		pmem_rdata <= physical_rdata_i;

	cache #(.index_bits(index_bits)) i_cache (
		.clk, .rst_i, .req_i(inst_req), .pmem_resp_i(i_pmem_resp), .pmem_rdata_i(pmem_rdata),
		.resp_o(inst_resp_o), .pmem_req_o(i_pmem_req), .hit_o(i_hit), .miss_o(i_miss)
	);

	cache #(.index_bits(index_bits)) d_cache (
		.clk, .rst_i, .req_i(dcache_req), .pmem_resp_i(d_pmem_resp), .pmem_rdata_i(pmem_rdata),
		.resp_o(dcache_resp), .pmem_req_o(d_pmem_req), .hit_o(d_hit), .miss_o(d_miss)
	);

	cache_arbiter arbiter (
		.clk,
		.rst_i,
		.i_req_i(i_pmem_req),
		.d_req_i(d_pmem_req),
		.physical_resp_i,
		.physical_req_o(physical_req),
		.i_pmem_resp_o(i_pmem_resp),
		.d_pmem_resp_o(d_pmem_resp)
	);

	perf_io io (
		.clk, .rst_i, .req_i(io_req),
		.i_hit_i(i_hit), .i_miss_i(i_miss), .d_hit_i(d_hit), .d_miss_i(d_miss),
		.resp_o(io_resp)
	);

	assign physical_read_o = physical_req.read;
	assign physical_write_o = physical_req.write;
	assign physical_address_o = physical_req.address;
	assign physical_wdata_o = physical_req.wdata;

endmodule

`default_nettype wire

// ==== tb/mem_checker.sv ====
`default_nettype none

module mem_checker
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_i,
	input mem_resp_t inst_resp_i,
	input mem_resp_t data_resp_i,
	input logic inst_pending_i,
	input logic data_pending_i,
	input logic inst_read_i,
	input logic data_read_i,
	input lc3b_word inst_exp_i,
	input lc3b_word data_exp_i,
	input int inst_op_i,
	input int data_op_i,
	input logic report_i,
	output int pass_count_o,
	output int fail_count_o
);

	logic reported;

	// checks one port in one cycle
	task automatic check_port(
		input string name,
		input mem_resp_t resp,
		input logic pending,
		input logic is_read,
		input lc3b_word rdata_exp,
		input int op_num
	);
		if (resp.resp && !pending) begin
			$display("response on %s at time %0t without a request waiting", name, $time);
			fail_count_o = fail_count_o + 1;
		end else if (resp.resp && is_read && resp.rdata !== rdata_exp) begin
			$display("[FAIL] time %0t %s.rdata expected %h got %h in op %0d",
				$time, name, rdata_exp, resp.rdata, op_num);
			fail_count_o = fail_count_o + 1;
		end else if (resp.resp && is_read) begin
			$display("[PASS] op %0d %s read %h", op_num, name, resp.rdata);
			pass_count_o = pass_count_o + 1;
		end else if (resp.resp) begin
			$display("[PASS] op %0d %s write acknowledged", op_num, name);
			pass_count_o = pass_count_o + 1;
		end
	endtask

	// responses sampled at the rising edge before they update
	always @(posedge clk) begin
		if (rst_i) begin
			pass_count_o = 0;
			fail_count_o = 0;
			reported = 1'b0;
		end else begin
			check_port("inst_resp_o", inst_resp_i, inst_pending_i, inst_read_i,
				inst_exp_i, inst_op_i);
			check_port("data_resp_o", data_resp_i, data_pending_i, data_read_i,
				data_exp_i, data_op_i);
			if (report_i && !reported) begin
				$display("%0d responses checked, %0d passed, %0d failed",
					pass_count_o + fail_count_o, pass_count_o, fail_count_o);
				reported = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_lc3b_memory.sv ====
`default_nettype none

module tb_lc3b_memory
	import lc3b_types::*;
();

	// one line of the golden file
	typedef struct packed {
		logic is_data;
		logic is_write;
		lc3b_word addr;
		lc3b_word wdata;
		lc3b_mem_wmask mask;
		lc3b_word rdata_exp;
		logic parallel;
	} golden_op_t;

	localparam int max_ops = 64;

	logic clk;
	logic rst_i;
	mem_req_t inst_req;
	mem_req_t data_req;
	mem_resp_t inst_resp;
	mem_resp_t data_resp;
	logic physical_resp;
	lc3b_line physical_rdata;
	logic physical_read;
	logic physical_write;
	lc3b_word physical_address;
	lc3b_line physical_wdata;

	// current request on each port for the checker
	logic inst_pending;
	logic data_pending;
	logic inst_read;
	logic data_read;
	lc3b_word inst_exp;
	lc3b_word data_exp;
	int inst_op;
	int data_op;
	logic report;
	int pass_count;
	int fail_count;

	golden_op_t ops [max_ops];
	int n_ops;
	logic ops_ready;
	lc3b_line phys_mem [lc3b_word];

	lc3b_memory #(.index_bits(3)) lc3b_memory_i (
		.clk,
		.rst_i,
		.inst_req_i(inst_req),
		.data_req_i(data_req),
		.physical_resp_i(physical_resp),
		.physical_rdata_i(physical_rdata),
		.inst_resp_o(inst_resp),
		.data_resp_o(data_resp),
		.physical_read_o(physical_read),
		.physical_write_o(physical_write),
		.physical_address_o(physical_address),
		.physical_wdata_o(physical_wdata)
	);

	mem_checker resp_checker (
		.clk,
		.rst_i,
		.inst_resp_i(inst_resp),
		.data_resp_i(data_resp),
		.inst_pending_i(inst_pending),
		.data_pending_i(data_pending),
		.inst_read_i(inst_read),
		.data_read_i(data_read),
		.inst_exp_i(inst_exp),
		.data_exp_i(data_exp),
		.inst_op_i(inst_op),
		.data_op_i(data_op),
		.report_i(report),
		.pass_count_o(pass_count),
		.fail_count_o(fail_count)
	);

	always #50 clk = ~clk;

	task automatic load_golden();
		int fd;
		int got;
		int par;
		logic [7:0] port_c;
		logic [7:0] op_c;
		lc3b_word addr;
		lc3b_word wdata;
		lc3b_mem_wmask mask;
		lc3b_word rdata_exp;
		logic [8*128-1:0] rest;
		n_ops = 0;
		fd = $fopen("tb/golden_ops.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/golden_ops.txt");
			return;
		end
		got = $fscanf(fd, " %s", port_c);
		while (got == 1 && n_ops < max_ops) begin
			if (port_c == "#") begin
				// column notes run to the end of the line
				got = $fgets(rest, fd);
			end else begin
				got = $fscanf(fd, " %s %h %h %h %h %d", op_c, addr, wdata, mask, rdata_exp, par);
				ops[n_ops].is_data = (port_c == "D");
				ops[n_ops].is_write = (op_c == "W");
				ops[n_ops].addr = addr;
				ops[n_ops].wdata = wdata;
				ops[n_ops].mask = mask;
				ops[n_ops].rdata_exp = rdata_exp;
				ops[n_ops].parallel = (par != 0);
				n_ops++;
			end
			got = $fscanf(fd, " %s", port_c);
		end
		$fclose(fd);
	endtask

	// unwritten lines hold each word's own byte address xor 5a5a
	function automatic lc3b_line read_line(input lc3b_word base);
		lc3b_line line;
		if (phys_mem.exists(base)) begin
			line = phys_mem[base];
		end else begin
			for (int k = 0; k < 8; k++)
				line[k*16 +: 16] = (base + lc3b_word'(2 * k)) ^ 16'h5a5a;
		end
		return line;
	endfunction

	// present one request on the falling edge and hold it until resp
	task automatic run_op(input int idx);
		golden_op_t op;
		mem_req_t req;
		op = ops[idx];
		req.read = !op.is_write;
		req.write = op.is_write;
		req.address = op.addr;
		req.wdata = op.wdata;
		req.byte_enable = op.mask;
		if (op.is_data) begin
			data_req = req;
			data_read = !op.is_write;
			data_exp = op.rdata_exp;
			data_op = idx;
			data_pending = 1'b1;
			do @(posedge clk); while (!data_resp.resp);
			@(negedge clk);
			data_req = '0;
			data_pending = 1'b0;
		end else begin
			inst_req = req;
			inst_read = !op.is_write;
			inst_exp = op.rdata_exp;
			inst_op = idx;
			inst_pending = 1'b1;
			do @(posedge clk); while (!inst_resp.resp);
			@(negedge clk);
			inst_req = '0;
			inst_pending = 1'b0;
		end
	endtask

	// physical memory with a random response delay of 2 to 6 cycles
	initial begin
		int delay;
		delay = int'($urandom(32'hc128_310d));
		physical_resp = 1'b0;
		physical_rdata = '0;
		forever begin
			@(negedge clk);
			if (!rst_i && (physical_read || physical_write)) begin
				delay = 2 + int'($urandom % 5);
				repeat (delay - 1) @(negedge clk);
				if (physical_write)
					phys_mem[physical_address] = physical_wdata;
				else
					physical_rdata = read_line(physical_address);
				physical_resp = 1'b1;
				@(negedge clk);
				physical_resp = 1'b0;
			end
		end
	end

	initial begin
		wait (ops_ready);
		repeat (n_ops * 200 + 16) @(posedge clk);
		$display("timeout after %0d cycles with a request still waiting", n_ops * 200 + 16);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int idx;
		clk = 1'b0;
		rst_i = 1'b1;
		inst_req = '0;
		data_req = '0;
		inst_pending = 1'b0;
		data_pending = 1'b0;
		inst_read = 1'b0;
		data_read = 1'b0;
		inst_exp = '0;
		data_exp = '0;
		inst_op = 0;
		data_op = 0;
		report = 1'b0;
		ops_ready = 1'b0;
		load_golden();
		if (n_ops == 0) begin
			$display("no operations could be read from tb/golden_ops.txt");
			$display("Verification failed");
			$finish;
		end else begin
			ops_ready = 1'b1;
			repeat (16) @(negedge clk);
			rst_i = 1'b0;
			idx = 0;
			while (idx < n_ops) begin
				if (ops[idx].parallel && idx + 1 < n_ops) begin
					fork
						run_op(idx);
						run_op(idx + 1);
					join
					idx += 2;
				end else begin
					run_op(idx);
					idx += 1;
				end
			end
			report = 1'b1;
			@(posedge clk);
			@(negedge clk);
			if (fail_count == 0 && pass_count == n_ops) begin
				$display("Verification passed");
			end else begin
				if (pass_count + fail_count != n_ops)
					$display("%0d responses seen for %0d operations",
						pass_count + fail_count, n_ops);
				$display("Verification failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb/golden_ops.txt ====
# port op address wdata mask expected_rdata parallel
# port is I or D and op is R or W with hex values and parallel 1 issuing with the next line
I R 0040 0000 3 5a1a 0
I R 0042 0000 3 5a18 0
I R 004e 0000 3 5a14 0
I R 0046 0000 3 5a1c 0
D W 0100 1234 1 0000 0
D R 0100 0000 3 5b34 0
D W 0102 abcd 2 0000 0
D R 0102 0000 3 ab58 0
D W 0104 c0de 3 0000 0
D R 0104 0000 3 c0de 0
D W 0106 ffff 0 0000 0
D R 0106 0000 3 5b5c 0
D R 0180 0000 3 5bda 0
D R 0100 0000 3 5b34 0
D R 0102 0000 3 ab58 0
D R 0104 0000 3 c0de 0
I R 0200 0000 3 585a 1
D R 0310 0000 3 594a 0
I R 0250 0000 3 580a 1
D R 0420 0000 3 5e7a 0
D R fff0 0000 3 0003 0
D R fff2 0000 3 0003 0
D R fff4 0000 3 0009 0
D R fff6 0000 3 0005 0
D W fff0 0000 3 0000 0
D R fff4 0000 3 0000 0
D R 0104 0000 3 c0de 0
D R fff4 0000 3 0001 0

// ==== lc3b_memory.f ====
src/lc3b_types.sv
src/cache_control.sv
src/cache.sv
src/cache_arbiter.sv
src/perf_io.sv
src/lc3b_memory.sv
tb/mem_checker.sv
tb/tb_lc3b_memory.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_lc3b_memory
FILELIST = lc3b_memory.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
